//--- tb/mipsCore_stimulus.txt
// words 000-07F program from 0xBFC00000, 080-0BF initial data words,
// 0C0 record count, then records: test id, pc, register, value
@000
24010005 2402FFFD 00221821 00222023
3C051234 34A58765 30A6F0F0 00A63826
0041402A 0022482A 00015100 00055A02
00A76024 00246825 8C0E0000 01C17821
01EF8021 020F8823 8C120004 00329825
10240002 24140001 26940002 14240002
24150007 24150063 10210002 24160016
24160BAD 0FF00022 24170023 0BF00024
24180024 24180BAD 03E00008 24190025
AC050008 A0010009 241AFF80 A01A000B
8C1B0008 801C000B 801D0009 801E0005
80020006 03C21821 0BF0002E 00000000
@080
11223344 80FF7F01 00000000 00000000
@0C0
00000023
00000001 BFC00000 00000001 00000005
00000001 BFC00004 00000002 FFFFFFFD
00000001 BFC00008 00000003 00000002
00000001 BFC0000C 00000004 00000008
00000001 BFC00010 00000005 12340000
00000001 BFC00014 00000005 12348765
00000001 BFC00018 00000006 00008060
00000001 BFC0001C 00000007 12340705
00000001 BFC00020 00000008 00000001
00000001 BFC00024 00000009 00000000
00000001 BFC00028 0000000A 00000050
00000001 BFC0002C 0000000B 00123487
00000001 BFC00030 0000000C 12340705
00000001 BFC00034 0000000D 0000000D
00000002 BFC00038 0000000E 11223344
00000002 BFC0003C 0000000F 11223349
00000002 BFC00040 00000010 22446692
00000002 BFC00044 00000011 11223349
00000002 BFC00048 00000012 80FF7F01
00000002 BFC0004C 00000013 80FF7F05
00000003 BFC00054 00000014 00000001
00000003 BFC00058 00000014 00000003
00000003 BFC00060 00000015 00000007
00000003 BFC0006C 00000016 00000016
00000003 BFC00074 0000001F BFC0007C
00000003 BFC00078 00000017 00000023
00000003 BFC0008C 00000019 00000025
00000003 BFC00080 00000018 00000024
00000004 BFC00098 0000001A FFFFFF80
00000004 BFC000A0 0000001B 80340565
00000004 BFC000A4 0000001C FFFFFF80
00000004 BFC000A8 0000001D 00000005
00000004 BFC000AC 0000001E 0000007F
00000004 BFC000B0 00000002 FFFFFFFF
00000004 BFC000B4 00000003 0000007E

//--- src.f
logic/mipsPkg.sv
logic/alu.sv
logic/memCtrl.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/mainDecoder.sv
logic/datapath.sv
logic/mipsCore.sv
tb/mipsCore_chk.sv
tb/mipsCore_tb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - logic/mipsPkg.sv
  - logic/alu.sv
  - logic/memCtrl.sv
  - logic/regFile.sv
  - logic/hazardUnit.sv
  - logic/mainDecoder.sv
  - logic/datapath.sv
  - logic/mipsCore.sv
  - target: simulation
    files:
      - tb/mipsCore_chk.sv
      - tb/mipsCore_tb.sv

//--- tb/mipsCore_tb.sv
`timescale 1ns/10ps

module mipsCore_tb;

    localparam int StimWords = 512;
    localparam int DataBase  = 'h80;   // initial data words
    localparam int TraceBase = 'hC0;   // record count followed by 4-word records

    logic        clk;
    logic        reset_i;
    logic [31:0] instAddr_o;
    logic        instEn_o;
    logic [31:0] instr_i;
    logic        iStall_i;
    logic        memEn_o;
    logic [31:0] memAddr_o;
    logic [3:0]  memWen_o;
    logic [31:0] memWdata_o;
    logic [31:0] memRdata_i;
    logic        dStall_i;
    logic [31:0] debugPc_o;
    logic        debugWen_o;
    logic [4:0]  debugWnum_o;
    logic [31:0] debugWdata_o;

    logic [31:0] stim [StimWords];
    logic [31:0] instMem [1024];
    logic [31:0] dataMem [64];

    int  traceLen;
    int  recIdx;
    int  limit;
    int  cycleCount;
    int  checkCount;
    int  errCount;
    int  assertFails;
    int  testChecks;
    int  testErrs;
    bit  stallOn;
    bit  stallRun;
    bit  running;

    mipsCore mipsCore_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // combinational memories answer in the same cycle
    assign instr_i    = instEn_o ? instMem[instAddr_o[11:2]] : '0;
    assign memRdata_i = dataMem[memAddr_o[7:2]];

    always @(posedge clk) begin
        if (memEn_o && memWen_o != 4'b0000) begin
            for (int b = 0; b < 4; b++) begin
                if (memWen_o[b])
                    dataMem[memAddr_o[7:2]][8*b +: 8] <= memWdata_o[8*b +: 8];
            end
        end
    end

    // each stall level is high on about one cycle in five
    initial begin
        int unsigned iDraw;
        int unsigned dDraw;
        void'($urandom(32'h34ce114f));
        forever begin
            @(posedge clk);
            #1;
            iDraw    = $urandom % 5;
            dDraw    = $urandom % 5;
            iStall_i = stallOn && iDraw == 0;
            dStall_i = stallOn && dDraw == 0;
        end
    end

    always @(negedge clk) begin
        if (running && debugWen_o)
            checkEntry();
    end

    function automatic string testName(input int id);
        case (id)
            1:       return "alu and immediates";
            2:       return "forwarding and load-use";
            3:       return "control transfers";
            4:       return "byte and word memory";
            default: return "random stalls";
        endcase
    endfunction

    task automatic reportTest(input int id);
        $display("test %0d %s: %0d checks, %0d errors", id, testName(id), testChecks, testErrs);
        testChecks = 0;
        testErrs   = 0;
    endtask

    task automatic checkEntry();
        int          base;
        int          testId;
        int          nextId;
        logic [31:0] expPc;
        logic [31:0] expNum;
        logic [31:0] expData;
        assert (recIdx < traceLen) else begin
            $display("unexpected extra trace entry at %0t, pc %h", $time, debugPc_o);
            errCount++;
        end
        if (recIdx >= traceLen)
            return;
        base    = TraceBase + 1 + 4 * recIdx;
        testId  = stallRun ? 5 : int'(stim[base]);
        expPc   = stim[base + 1];
        expNum  = stim[base + 2];
        expData = stim[base + 3];
        assert (debugPc_o == expPc) else begin
            $display("ERR %0t debugPc_o expected %h got %h", $time, expPc, debugPc_o);
            errCount++;
            testErrs++;
        end
        assert (debugWnum_o == expNum[4:0]) else begin
            $display("ERR %0t debugWnum_o expected %0d got %0d", $time, expNum, debugWnum_o);
            errCount++;
            testErrs++;
        end
        assert (debugWdata_o == expData) else begin
            $display("ERR %0t debugWdata_o expected %h got %h", $time, expData, debugWdata_o);
            errCount++;
            testErrs++;
        end
        checkCount++;
        testChecks++;
        recIdx++;
        if (recIdx < traceLen)
            nextId = stallRun ? 5 : int'(stim[base + 4]);
        else
            nextId = 0;
        if (nextId != testId)
            reportTest(testId);
    endtask

    task automatic loadMemories();
        for (int i = 0; i < 1024; i++)
            instMem[i] = (i < DataBase && !$isunknown(stim[i])) ? stim[i] : 32'h0;  // nops past the program
        for (int i = 0; i < 64; i++)
            dataMem[i] = stim[DataBase + i];
    endtask

    task automatic runProgram(input bit withStalls);
        loadMemories();
        recIdx   = 0;
        stallRun = withStalls;
        stallOn  = withStalls;
        reset_i  = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;
        running = 1'b1;
        cycleCount = 0;
        while (recIdx < traceLen) begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > limit) begin
                $display("timeout: trace stalled at entry %0d of %0d", recIdx, traceLen);
                $display("Done: errors found");
                $finish;
            end
        end
        repeat (10) @(posedge clk);  // catch stray extra entries
        #1;
        running = 1'b0;
        stallOn = 1'b0;
    endtask

    initial begin
        reset_i    = 1'b1;
        iStall_i   = 1'b0;
        dStall_i   = 1'b0;
        stallOn    = 1'b0;
        stallRun   = 1'b0;
        running    = 1'b0;
        checkCount = 0;
        errCount   = 0;
        testChecks = 0;
        testErrs   = 0;
        $readmemh("tb/mipsCore_stimulus.txt", stim);
        traceLen = int'(stim[TraceBase]);
        limit    = 20 * traceLen + 200;
        runProgram(1'b0);
        runProgram(1'b1);
        assertFails = mipsCore_inst.mipsCore_chk_inst.failCount;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errCount, assertFails);
        if (errCount == 0 && assertFails == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- tb/mipsCore_chk.sv
`timescale 1ns/10ps

module mipsCore_chk (
    input logic        clk,
    input logic        reset_i,
    input logic        instEn_o,
    input logic        memEn_o,
    input logic [31:0] memAddr_o,
    input logic [3:0]  memWen_o,
    input logic        debugWen_o,
    input logic [4:0]  debugWnum_o
);

    int failCount = 0;  // summed into the testbench error count

    // enables low from the first reset edge through the cycle after reset
    assert property (@(posedge clk) reset_i |=> !instEn_o && !memEn_o)
        else begin
            $error("memory enable high during reset");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset_i)
        memEn_o && memWen_o == 4'b1111 |-> memAddr_o[1:0] == 2'b00)
        else begin
            $error("word store to unaligned address");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset_i)
        memWen_o != 4'b0000 |-> memEn_o)
        else begin
            $error("byte enables without memory enable");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset_i)
        debugWen_o |-> debugWnum_o != 5'd0)
        else begin
            $error("trace reports a write to register 0");
            failCount++;
        end

endmodule

bind mipsCore mipsCore_chk mipsCore_chk_inst (.*);

//--- logic/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
    input  logic        clk,
    input  logic        reset_i,
    output logic [31:0] instAddr_o,
    output logic        instEn_o,
    input  logic [31:0] instr_i,
    input  logic        iStall_i,
    output logic        memEn_o,
    output logic [31:0] memAddr_o,
    output logic [3:0]  memWen_o,
    output logic [31:0] memWdata_o,
    input  logic [31:0] memRdata_i,
    input  logic        dStall_i,
    output logic [31:0] debugPc_o,
    output logic        debugWen_o,
    output logic [4:0]  debugWnum_o,
    output logic [31:0] debugWdata_o
);

    datapath datapath_inst (.*);  // ports match one to one

endmodule

//--- logic/datapath.sv
`timescale 1ns/10ps

module datapath (
    input  logic        clk,
    input  logic        reset_i,
    output logic [31:0] instAddr_o,
    output logic        instEn_o,
    input  logic [31:0] instr_i,
    input  logic        iStall_i,
    output logic        memEn_o,
    output logic [31:0] memAddr_o,
    output logic [3:0]  memWen_o,
    output logic [31:0] memWdata_o,
    input  logic [31:0] memRdata_i,
    input  logic        dStall_i,
    output logic [31:0] debugPc_o,
    output logic        debugWen_o,
    output logic [4:0]  debugWnum_o,
    output logic [31:0] debugWdata_o
);

    mipsPkg::ifIdT  ifId;
    mipsPkg::idExT  idEx;
    mipsPkg::exMemT exMem;
    mipsPkg::memWbT memWb;
    mipsPkg::ctrlT  ctrlD;

    logic [31:0] pcF, pcNext, pcPlus4D, immD;
    logic        fetchOn;  // low for one cycle after reset
    logic [31:0] rd1D, rd2D;
    logic        freeze, stallFD, flushE, flushD;
    logic [1:0]  forwardA, forwardB;
    logic [31:0] srcA, rtFwd, srcB, aluOutE, branchTarget, redirectTarget;
    logic        redirectE;
    logic [31:0] loadDataM, resultM;

    function automatic logic [31:0] pickOperand(input logic [1:0] sel, input logic [31:0] regVal);
        case (sel)
            2'b01:   return exMem.aluResult;
            2'b10:   return memWb.result;
            default: return regVal;
        endcase
    endfunction

    hazardUnit hazardUnit_inst (
        .rsD_i(ifId.instr[25:21]), .rtD_i(ifId.instr[20:16]),
        .rsE_i(idEx.rs), .rtE_i(idEx.rt),
        .loadE_i(idEx.ctrl.memRead), .rdE_i(idEx.ctrl.rd),
        .regWriteM_i(exMem.ctrl.regWrite), .rdM_i(exMem.ctrl.rd),
        .regWriteW_i(memWb.regWrite), .rdW_i(memWb.rd),
        .redirectE_i(redirectE), .iStall_i(iStall_i), .dStall_i(dStall_i),
        .freeze_o(freeze), .stallFD_o(stallFD), .flushE_o(flushE), .flushD_o(flushD),
        .forwardA_o(forwardA), .forwardB_o(forwardB)
    );

    assign instAddr_o = pcF;
    assign instEn_o   = fetchOn;
    assign pcNext     = redirectE ? redirectTarget : pcF + 32'd4;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pcF     <= mipsPkg::ResetPc;
            fetchOn <= 1'b0;
        end else begin
            fetchOn <= 1'b1;
            if (!freeze && fetchOn && !stallFD)
                pcF <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ifId.instr <= '0;
        end else if (!freeze) begin
            if (flushD)
                ifId.instr <= '0;  // wrong-path slot becomes a nop
            else if (!stallFD)
                ifId <= '{pc: pcF, instr: fetchOn ? instr_i : '0};
        end
    end

    mainDecoder mainDecoder_inst (.instr_i(ifId.instr), .ctrl_o(ctrlD));

    regFile regFile_inst (
        .clk(clk), .we_i(memWb.regWrite & ~freeze),
        .ra1_i(ifId.instr[25:21]), .ra2_i(ifId.instr[20:16]),
        .wa_i(memWb.rd), .wd_i(memWb.result),
        .rd1_o(rd1D), .rd2_o(rd2D)
    );

    assign pcPlus4D = ifId.pc + 32'd4;
    assign immD = ctrlD.signExt ? {{16{ifId.instr[15]}}, ifId.instr[15:0]}
                                : {16'h0000, ifId.instr[15:0]};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            idEx.ctrl <= '0;
        end else if (!freeze) begin
            if (flushE)
                idEx.ctrl <= '0;
            else
                idEx <= '{pc: ifId.pc, ctrl: ctrlD,
                          rs: ifId.instr[25:21], rt: ifId.instr[20:16],
                          rsVal: rd1D, rtVal: rd2D, imm: immD, shamt: ifId.instr[10:6],
                          jumpTarget: {pcPlus4D[31:28], ifId.instr[25:0], 2'b00}};
        end
    end

    always_comb begin
        srcA  = pickOperand(forwardA, idEx.rsVal);
        rtFwd = pickOperand(forwardB, idEx.rtVal);
    end

    assign srcB  = idEx.ctrl.immSel ? idEx.imm : rtFwd;

    alu alu_inst (.op_i(idEx.ctrl.aluOp), .a_i(srcA), .b_i(srcB), .shamt_i(idEx.shamt),
                  .result_o(aluOutE));

    assign branchTarget = idEx.pc + 32'd4 + {idEx.imm[29:0], 2'b00};

    // resolved in E while the delay slot in D keeps going
    always_comb begin
        redirectE      = 1'b1;
        redirectTarget = branchTarget;
        case (idEx.ctrl.brKind)
            mipsPkg::BrBeq:              redirectE = (srcA == rtFwd);
            mipsPkg::BrBne:              redirectE = (srcA != rtFwd);
            mipsPkg::BrJ, mipsPkg::BrJal: redirectTarget = idEx.jumpTarget;
            mipsPkg::BrJr:               redirectTarget = srcA;
            default:                     redirectE = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i)
            exMem.ctrl <= '0;
        else if (!freeze)
            exMem <= '{pc: idEx.pc, ctrl: idEx.ctrl,
                       aluResult: idEx.ctrl.link ? idEx.pc + 32'd8 : aluOutE,
                       storeData: rtFwd};
    end

    memCtrl memCtrl_inst (
        .size_i(exMem.ctrl.memSize), .loadSigned_i(exMem.ctrl.loadSigned),
        .write_i(exMem.ctrl.memWrite), .addr_i(exMem.aluResult),
        .wdata_i(exMem.storeData), .rdata_i(memRdata_i),
        .wen_o(memWen_o), .wdataLane_o(memWdata_o), .rdataExt_o(loadDataM)
    );

    assign memEn_o   = exMem.ctrl.memRead | exMem.ctrl.memWrite;
    assign memAddr_o = exMem.aluResult;
    assign resultM   = exMem.ctrl.memRead ? loadDataM : exMem.aluResult;

    always_ff @(posedge clk) begin
        if (reset_i)
            memWb.regWrite <= 1'b0;
        else if (!freeze)
            memWb <= '{pc: exMem.pc, regWrite: exMem.ctrl.regWrite, rd: exMem.ctrl.rd,
                       result: resultM};
    end

    // one trace entry per retired write and none while frozen
    assign debugPc_o    = memWb.pc;
    assign debugWen_o   = memWb.regWrite && (memWb.rd != '0) && !freeze;
    assign debugWnum_o  = memWb.rd;
    assign debugWdata_o = memWb.result;

endmodule

//--- logic/mainDecoder.sv
`timescale 1ns/10ps

module mainDecoder (
    input  logic [mipsPkg::DataWidth-1:0] instr_i,
    output mipsPkg::ctrlT                 ctrl_o
);

    logic [mipsPkg::RegAddrWidth-1:0] rt;
    logic [mipsPkg::RegAddrWidth-1:0] rd;

    assign rt = instr_i[20:16];
    assign rd = instr_i[15:11];

    always_comb begin
        ctrl_o = '0;
        case (mipsPkg::opcodeT'(instr_i[31:26]))
            mipsPkg::OpSpecial: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.rd       = rd;
                case (mipsPkg::functT'(instr_i[5:0]))
                    mipsPkg::FnAddu: ctrl_o.aluOp = mipsPkg::AluAdd;
                    mipsPkg::FnSubu: ctrl_o.aluOp = mipsPkg::AluSub;
                    mipsPkg::FnAnd:  ctrl_o.aluOp = mipsPkg::AluAnd;
                    mipsPkg::FnOr:   ctrl_o.aluOp = mipsPkg::AluOr;
                    mipsPkg::FnXor:  ctrl_o.aluOp = mipsPkg::AluXor;
                    mipsPkg::FnSlt:  ctrl_o.aluOp = mipsPkg::AluSlt;
                    mipsPkg::FnSll:  ctrl_o.aluOp = mipsPkg::AluSll;
                    mipsPkg::FnSrl:  ctrl_o.aluOp = mipsPkg::AluSrl;
                    mipsPkg::FnJr: begin
                        ctrl_o.regWrite = 1'b0;
                        ctrl_o.rd       = '0;
                        ctrl_o.brKind   = mipsPkg::BrJr;
                    end
                    default: ctrl_o = '0;  // unknown funct acts as nop
                endcase
            end
            mipsPkg::OpAddiu, mipsPkg::OpAndi, mipsPkg::OpOri, mipsPkg::OpLui: begin
                ctrl_o.immSel   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.rd       = rt;
                ctrl_o.signExt  = (instr_i[31:26] == mipsPkg::OpAddiu);  // andi/ori zero-extend
                case (mipsPkg::opcodeT'(instr_i[31:26]))
                    mipsPkg::OpAndi: ctrl_o.aluOp = mipsPkg::AluAnd;
                    mipsPkg::OpOri:  ctrl_o.aluOp = mipsPkg::AluOr;
                    mipsPkg::OpLui:  ctrl_o.aluOp = mipsPkg::AluLui;
                    default:         ctrl_o.aluOp = mipsPkg::AluAdd;
                endcase
            end
            mipsPkg::OpLw, mipsPkg::OpLb, mipsPkg::OpSw, mipsPkg::OpSb: begin
                ctrl_o.immSel     = 1'b1;
                ctrl_o.signExt    = 1'b1;
                ctrl_o.aluOp      = mipsPkg::AluAdd;  // base + offset
                ctrl_o.memRead    = !instr_i[29];
                ctrl_o.memWrite   = instr_i[29];
                ctrl_o.regWrite   = !instr_i[29];
                ctrl_o.rd         = instr_i[29] ? '0 : rt;
                ctrl_o.memSize    = instr_i[27] ? mipsPkg::MemWord : mipsPkg::MemByte;
                ctrl_o.loadSigned = !instr_i[27];
            end
            mipsPkg::OpBeq, mipsPkg::OpBne: begin
                ctrl_o.signExt = 1'b1;
                ctrl_o.brKind  = instr_i[26] ? mipsPkg::BrBne : mipsPkg::BrBeq;
            end
            mipsPkg::OpJ: ctrl_o.brKind = mipsPkg::BrJ;
            mipsPkg::OpJal: begin
                ctrl_o.brKind   = mipsPkg::BrJal;
                ctrl_o.link     = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.rd       = 5'd31;  // ra
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  logic [mipsPkg::RegAddrWidth-1:0] rsD_i,
    input  logic [mipsPkg::RegAddrWidth-1:0] rtD_i,
    input  logic [mipsPkg::RegAddrWidth-1:0] rsE_i,
    input  logic [mipsPkg::RegAddrWidth-1:0] rtE_i,
    input  logic                             loadE_i,
    input  logic [mipsPkg::RegAddrWidth-1:0] rdE_i,
    input  logic                             regWriteM_i,
    input  logic [mipsPkg::RegAddrWidth-1:0] rdM_i,
    input  logic                             regWriteW_i,
    input  logic [mipsPkg::RegAddrWidth-1:0] rdW_i,
    input  logic                             redirectE_i,
    input  logic                             iStall_i,
    input  logic                             dStall_i,
    output logic                             freeze_o,
    output logic                             stallFD_o,
    output logic                             flushE_o,
    output logic                             flushD_o,
    output logic [1:0]                       forwardA_o,
    output logic [1:0]                       forwardB_o
);

    logic loadUse;

    // 01 from M, 10 from W, 00 from the register file
    function automatic logic [1:0] fwdSel(input logic [mipsPkg::RegAddrWidth-1:0] src);
        if (src == '0)
            return 2'b00;
        else if (regWriteM_i && rdM_i == src)
            return 2'b01;  // youngest producer wins
        else if (regWriteW_i && rdW_i == src)
            return 2'b10;
        else
            return 2'b00;
    endfunction

    assign loadUse = loadE_i && (rdE_i != '0) && (rdE_i == rsD_i || rdE_i == rtD_i);

    assign freeze_o   = iStall_i | dStall_i;
    assign stallFD_o  = loadUse;
    assign flushE_o   = loadUse;      // bubble behind the load
    assign flushD_o   = redirectE_i;  // drop the wrong-path fetch

    always_comb begin
        forwardA_o = fwdSel(rsE_i);
        forwardB_o = fwdSel(rtE_i);
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic                             clk,
    input  logic                             we_i,
    input  logic [mipsPkg::RegAddrWidth-1:0] ra1_i,
    input  logic [mipsPkg::RegAddrWidth-1:0] ra2_i,
    input  logic [mipsPkg::RegAddrWidth-1:0] wa_i,
    input  logic [mipsPkg::DataWidth-1:0]    wd_i,
    output logic [mipsPkg::DataWidth-1:0]    rd1_o,
    output logic [mipsPkg::DataWidth-1:0]    rd2_o
);

    logic [mipsPkg::DataWidth-1:0] regs [2**mipsPkg::RegAddrWidth];

    // write-first read with r0 tied low
    function automatic logic [mipsPkg::DataWidth-1:0] readPort(
        input logic [mipsPkg::RegAddrWidth-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (we_i && wa_i == addr)
            return wd_i;  // bypass the W-stage write
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we_i)
            regs[wa_i] <= wd_i;
    end

    always_comb begin
        rd1_o = readPort(ra1_i);
        rd2_o = readPort(ra2_i);
    end

endmodule

//--- logic/memCtrl.sv
`timescale 1ns/10ps

module memCtrl (
    input  mipsPkg::memSizeT              size_i,
    input  logic                          loadSigned_i,
    input  logic                          write_i,
    input  logic [mipsPkg::DataWidth-1:0] addr_i,
    input  logic [mipsPkg::DataWidth-1:0] wdata_i,
    input  logic [mipsPkg::DataWidth-1:0] rdata_i,
    output logic [3:0]                    wen_o,
    output logic [mipsPkg::DataWidth-1:0] wdataLane_o,
    output logic [mipsPkg::DataWidth-1:0] rdataExt_o
);

    logic       isWord;
    logic [7:0] loadByte;

    assign isWord   = (size_i == mipsPkg::MemWord);
    assign loadByte = rdata_i[{addr_i[1:0], 3'b000} +: 8];  // little-endian lane

    always_comb begin
        if (!write_i)
            wen_o = 4'b0000;
        else if (isWord)
            wen_o = 4'b1111;
        else
            wen_o = 4'b0001 << addr_i[1:0];
    end

    // sb byte copied to every lane, wen picks one
    assign wdataLane_o = isWord ? wdata_i : {4{wdata_i[7:0]}};

    assign rdataExt_o = isWord ? rdata_i : {{24{loadSigned_i & loadByte[7]}}, loadByte};

endmodule

//--- logic/alu.sv
`timescale 1ns/10ps

module alu (
    input  mipsPkg::aluOpT                op_i,
    input  logic [mipsPkg::DataWidth-1:0] a_i,
    input  logic [mipsPkg::DataWidth-1:0] b_i,
    input  logic [4:0]                    shamt_i,
    output logic [mipsPkg::DataWidth-1:0] result_o
);

    always_comb begin
        case (op_i)
            mipsPkg::AluAdd: result_o = a_i + b_i;  // no overflow trap
            mipsPkg::AluSub: result_o = a_i - b_i;
            mipsPkg::AluAnd: result_o = a_i & b_i;
            mipsPkg::AluOr:  result_o = a_i | b_i;
            mipsPkg::AluXor: result_o = a_i ^ b_i;
            mipsPkg::AluSlt: begin
                result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            end
            // shifts take rt through b
            mipsPkg::AluSll: result_o = b_i << shamt_i;
            mipsPkg::AluSrl: result_o = b_i >> shamt_i;
            mipsPkg::AluLui: result_o = {b_i[15:0], 16'h0000};
            default:         result_o = '0;
        endcase
    end

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam logic [DataWidth-1:0] ResetPc = 32'hBFC00000;  // boot vector

    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpJ       = 6'h02,
        OpJal     = 6'h03,
        OpBeq     = 6'h04,
        OpBne     = 6'h05,
        OpAddiu   = 6'h09,
        OpAndi    = 6'h0C,
        OpOri     = 6'h0D,
        OpLui     = 6'h0F,
        OpLb      = 6'h20,
        OpLw      = 6'h23,
        OpSb      = 6'h28,
        OpSw      = 6'h2B
    } opcodeT;

    // funct field of SPECIAL
    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnJr   = 6'h08,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnSlt  = 6'h2A
    } functT;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSll, AluSrl, AluLui
    } aluOpT;

    typedef enum logic {MemByte, MemWord} memSizeT;

    typedef enum logic [2:0] {BrNone, BrBeq, BrBne, BrJ, BrJal, BrJr} brKindT;

    // all-zero value is a bubble
    typedef struct packed {
        aluOpT                   aluOp;
        logic                    immSel;
        logic                    signExt;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        memSizeT                 memSize;
        logic                    loadSigned;
        brKindT                  brKind;
        logic                    link;      // jal writes pc+8
        logic [RegAddrWidth-1:0] rd;
    } ctrlT;

    typedef struct packed {
        logic [DataWidth-1:0] pc;
        logic [DataWidth-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic [DataWidth-1:0]    pc;
        ctrlT                    ctrl;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [DataWidth-1:0]    rsVal;
        logic [DataWidth-1:0]    rtVal;
        logic [DataWidth-1:0]    imm;
        logic [4:0]              shamt;
        logic [DataWidth-1:0]    jumpTarget;
    } idExT;

    typedef struct packed {
        logic [DataWidth-1:0] pc;
        ctrlT                 ctrl;
        logic [DataWidth-1:0] aluResult;
        logic [DataWidth-1:0] storeData;
    } exMemT;

    typedef struct packed {
        logic [DataWidth-1:0]    pc;
        logic                    regWrite;
        logic [RegAddrWidth-1:0] rd;
        logic [DataWidth-1:0]    result;
    } memWbT;

endpackage
